// ==== Makefile ====
# Verilator build and run for acq_unit

VERILATOR ?= verilator
TOP       ?= acq_tb
FILELIST  ?= acq_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_TEXT ?= No errors

# Sources taken from the file list
SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The status of the run is the result of the search in the log
run: $(BIN) acq_golden.txt
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== acq_axis_framer.sv ====
`timescale 1ns/100ps

module acq_axis_framer
   (
   input  logic                 clock_i,
   input  logic                 M_AXIS_ARESETN,

   // FIFO head and status
   input  acq_pkg::sample_t     head_i,
   input  logic                 empty_i,
   output logic                 rd_en_o,

   // Stream master
   output acq_pkg::axis_beat_t  beat_o,
   output logic                 tvalid_o,
   input  logic                 tready_i,

   // High while a frame is part way out
   output logic                 frame_open_o
   );

   // Last beat index within a frame
   localparam logic [acq_pkg::FRAME_CW-1:0] LAST_BEAT =
      acq_pkg::FRAME_CW'(acq_pkg::FRAME_LEN - 1);

   // Accepted beats in the current frame
   logic [acq_pkg::FRAME_CW-1:0] beat_cnt;
   logic                         tvalid;
   logic                         accept;

   // --------------------------------------------------
   // Beat presentation
   // --------------------------------------------------
   // Valid whenever the FIFO has a word at its head
   assign tvalid = !empty_i;
   assign accept = tvalid && tready_i;

   // Head sample zero-extended onto tdata
   assign beat_o.tdata = {{(acq_pkg::TDATA_W - acq_pkg::SAMPLE_W){1'b0}}, head_i.data};
   // Final beat of the frame
   assign beat_o.tlast = (beat_cnt == LAST_BEAT);

   assign tvalid_o = tvalid;
   // Pop the FIFO on every accepted beat
   assign rd_en_o  = accept;

   // --------------------------------------------------
   // Frame beat counter
   // --------------------------------------------------
   // Counts only accepted beats, so tready gaps do not matter
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         beat_cnt <= '0;
      end
      else if (accept)
      begin
         if (beat_cnt == LAST_BEAT)
         begin
            beat_cnt <= '0;
         end
         else
         begin
            beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

   // Mid-frame status for the system register
   assign frame_open_o = (beat_cnt != '0);

endmodule

// ==== acq_capture.sv ====
`timescale 1ns/100ps

module acq_capture
   (
   input  logic                           clock_i,
   input  logic                           M_AXIS_ARESETN,

   // Raw antenna samples
   input  logic [acq_pkg::SAMPLE_W-1:0]   signal_i,
   input  logic                           strobe_i,

   // Control from the register slave
   input  logic                           enable_i,
   input  logic                           clear_oflow_i,

   // FIFO write side
   input  logic                           full_i,
   output logic                           wr_en_o,
   output acq_pkg::sample_t               wr_data_o,

   // Sticky overflow status
   output logic                           oflow_o
   );

   // A strobed sample while acquisition is enabled
   logic take;
   logic oflow;

   // --------------------------------------------------
   // Sample qualification
   // --------------------------------------------------
   assign take = strobe_i && enable_i;

   // Write only when there is room, the FIFO trusts this check
   assign wr_en_o        = take && !full_i;
   assign wr_data_o.data = signal_i;

   // --------------------------------------------------
   // Sticky overflow flag
   // --------------------------------------------------
   // Set by a sample that finds the FIFO full
   // Clearing wins over a set in the same cycle
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         oflow <= 1'b0;
      end
      else if (clear_oflow_i)
      begin
         oflow <= 1'b0;
      end
      else if (take && full_i)
      begin
         oflow <= 1'b1;
      end
   end

   assign oflow_o = oflow;

endmodule

// ==== acq_fifo.sv ====
`timescale 1ns/100ps

module acq_fifo
   (
   input  logic              clock_i,
   input  logic              M_AXIS_ARESETN,

   // Write side, fullness is checked by the writer
   input  logic              wr_en_i,
   input  acq_pkg::sample_t  wr_data_i,

   // Read side, first word falls through
   input  logic              rd_en_i,
   output acq_pkg::sample_t  rd_data_o,

   output logic              full_o,
   output logic              empty_o
   );

   // Storage for the sample records
   acq_pkg::sample_t mem [acq_pkg::FIFO_DEPTH];

   // Pointers carry one extra bit to tell full from empty
   logic [acq_pkg::FIFO_AW:0] wr_ptr;
   logic [acq_pkg::FIFO_AW:0] rd_ptr;

   // --------------------------------------------------
   // Storage write
   // --------------------------------------------------
   always_ff @(posedge clock_i)
   begin
      if (wr_en_i)
      begin
         mem[wr_ptr[acq_pkg::FIFO_AW-1:0]] <= wr_data_i;
      end
   end

   // --------------------------------------------------
   // Pointer update
   // --------------------------------------------------
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_en_i)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en_i)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Head word is visible while the FIFO holds data
   assign rd_data_o = mem[rd_ptr[acq_pkg::FIFO_AW-1:0]];

   // Same index, wrap bits differ when full
   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o  = (wr_ptr[acq_pkg::FIFO_AW] != rd_ptr[acq_pkg::FIFO_AW]) &&
                    (wr_ptr[acq_pkg::FIFO_AW-1:0] == rd_ptr[acq_pkg::FIFO_AW-1:0]);

endmodule

// ==== acq_golden.txt ====
# Columns: kind a b, both hex. W adr data, R adr expected, S first_sample count, P mode 0
# S count 0 is one cycle with strobe low. P mode 0 tready low, 1 high, 2 random, 1 and 2 drain
# Reset state and register map
R 3 00
W 3 80
R 3 80
R 0 00
R 1 00
R 2 00
# Ordered capture, strobe low cycles are ignored
P 1 0
S 0a0b0c 0
S 123456 2
S 000001 0
S fedcba 3
P 1 0
R 3 c0
# Disabled samples are lost, frame stays open
W 3 00
R 3 40
S 777777 2
W 3 80
S 111111 3
P 1 0
R 3 80
# Random tready gaps
P 2 0
S 200000 c
P 2 0
R 3 c0
S 300000 4
P 2 0
R 3 80
# Back-pressure, two samples past full
P 0 0
S 400000 12
R 3 88
P 1 0
R 3 88
# Disable clears overflow and stops capture
W 3 00
R 3 00
S 999999 1
P 1 0
R 3 00
W 3 80
S 010203 1
P 1 0
W 1 00
R 3 c0

// ==== acq_pkg.sv ====
package acq_pkg;

   // --------------------------------------------------
   // Data path widths
   // --------------------------------------------------
   // One raw antenna sample word
   localparam int SAMPLE_W = 24;
   // Stream data width, the sample is zero-extended into it
   localparam int TDATA_W  = 32;

   // --------------------------------------------------
   // Register bus
   // --------------------------------------------------
   localparam int BUS_W = 8;
   localparam int ADR_W = 2;

   // System register, the other addresses read as zero
   localparam logic [ADR_W-1:0] REG_SYSTEM = 2'd3;

   // System register bit positions
   localparam int BIT_ENABLE = 7;
   localparam int BIT_ACTIVE = 6;
   localparam int BIT_OFLOW  = 3;

   // --------------------------------------------------
   // Buffering and framing
   // --------------------------------------------------
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW    = 4;
   // Beats per frame and width of the beat counter
   localparam int FRAME_LEN  = 8;
   localparam int FRAME_CW   = 3;

   // One buffered sample record
   typedef struct packed {
      logic [SAMPLE_W-1:0] data;
   } sample_t;

   // Stream payload of one beat
   typedef struct packed {
      logic [TDATA_W-1:0] tdata;
      logic               tlast;
   } axis_beat_t;

   // Wishbone request, driven by the bus master
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [ADR_W-1:0] adr;
      logic [BUS_W-1:0] dat;
   } wb_req_t;

   // Wishbone response, driven by the register slave
   typedef struct packed {
      logic             ack;
      logic [BUS_W-1:0] dat;
   } wb_rsp_t;

endpackage

// ==== acq_regs.sv ====
`timescale 1ns/100ps

module acq_regs
   (
   input  logic              clock_i,
   input  logic              M_AXIS_ARESETN,

   // Wishbone classic slave port
   input  acq_pkg::wb_req_t  req_i,
   output acq_pkg::wb_rsp_t  rsp_o,

   // Status inputs
   input  logic              oflow_i,
   input  logic              frame_open_i,

   // Control outputs
   output logic              enable_o,
   output logic              clear_oflow_o
   );

   logic                      ack;
   logic [acq_pkg::BUS_W-1:0] rd_dat;
   logic                      enable;

   // Bus qualifiers
   logic                      stb_w;
   logic                      access;
   logic                      store;
   logic                      sys_sel;
   logic [acq_pkg::BUS_W-1:0] sys_reg;

   // --------------------------------------------------
   // Bus decode
   // --------------------------------------------------
   assign stb_w   = req_i.cyc && req_i.stb;
   // First cycle of a transfer only, no re-ack while ack is high
   assign access  = stb_w && !ack;
   assign store   = access && req_i.we;
   assign sys_sel = (req_i.adr == acq_pkg::REG_SYSTEM);

   // System register layout
   always_comb
   begin
      sys_reg                      = '0;
      sys_reg[acq_pkg::BIT_ENABLE] = enable;
      sys_reg[acq_pkg::BIT_ACTIVE] = frame_open_i;
      sys_reg[acq_pkg::BIT_OFLOW]  = oflow_i;
   end

   // --------------------------------------------------
   // Acknowledge
   // --------------------------------------------------
   // One cycle after stb, for exactly one cycle
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         ack <= 1'b0;
      end
      else
      begin
         ack <= access;
      end
   end

   // Read data captured at the edge that raises ack
   always_ff @(posedge clock_i)
   begin
      if (access && !req_i.we)
      begin
         rd_dat <= sys_sel ? sys_reg : '0;
      end
   end

   // --------------------------------------------------
   // Enable register
   // --------------------------------------------------
   always_ff @(posedge clock_i)
   begin
      if (!M_AXIS_ARESETN)
      begin
         enable <= 1'b0;
      end
      else if (store && sys_sel)
      begin
         enable <= req_i.dat[acq_pkg::BIT_ENABLE];
      end
   end

   // Disabling also clears the sticky overflow, at the same edge
   assign clear_oflow_o = store && sys_sel && !req_i.dat[acq_pkg::BIT_ENABLE];

   assign enable_o  = enable;
   assign rsp_o.ack = ack;
   assign rsp_o.dat = rd_dat;

endmodule

// ==== acq_tb.sv ====
`timescale 1ns/100ps

module acq_tb;

   localparam int          DATA_PAD  = acq_pkg::TDATA_W - acq_pkg::SAMPLE_W;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   // DUT inputs
   logic                         clock_i;
   logic                         M_AXIS_ARESETN;
   logic [acq_pkg::SAMPLE_W-1:0] signal_i;
   logic                         strobe_i;
   logic                         cyc_i;
   logic                         stb_i;
   logic                         we_i;
   logic [acq_pkg::ADR_W-1:0]    adr_i;
   logic [acq_pkg::BUS_W-1:0]    dat_i;
   logic                         axis_tready_i;

   // DUT outputs
   logic                         ack_o;
   logic [acq_pkg::BUS_W-1:0]    dat_o;
   logic                         axis_tvalid_o;
   logic [acq_pkg::TDATA_W-1:0]  axis_tdata_o;
   logic                         axis_tlast_o;
   logic                         enabled_o;
   logic                         oflow_o;

   // Golden records as a kind plus two hex fields
   logic [7:0]  kinds [$];
   logic [31:0] a_vals [$];
   logic [31:0] b_vals [$];

   // Reference model of the sample path
   logic [acq_pkg::SAMPLE_W-1:0] model_q [$];
   logic                         model_enable;
   logic                         model_oflow;
   int                           beats;

   // Beat offered but not taken on the last edge
   logic        held;
   logic [31:0] held_data;
   logic        held_last;

   // tready pattern where 0 is low, 1 high and 2 random gaps
   int          ready_mode;
   logic [31:0] lfsr;
   int          errors;
   int          checks;
   int          cycles;
   int          limit;
   bit          loaded;

   always #10 clock_i = ~clock_i;

   acq_top UUT (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .signal_i       (signal_i),
      .strobe_i       (strobe_i),
      .cyc_i          (cyc_i),
      .stb_i          (stb_i),
      .we_i           (we_i),
      .adr_i          (adr_i),
      .dat_i          (dat_i),
      .ack_o          (ack_o),
      .dat_o          (dat_o),
      .axis_tvalid_o  (axis_tvalid_o),
      .axis_tdata_o   (axis_tdata_o),
      .axis_tlast_o   (axis_tlast_o),
      .axis_tready_i  (axis_tready_i),
      .enabled_o      (enabled_o),
      .oflow_o        (oflow_o)
   );

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      begin
         checks = checks + 1;
         if (actual !== expected)
         begin
            errors = errors + 1;
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         end
      end
   endtask

   // Galois step shifts right and folds in the taps
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      begin
         if (state[0])
         begin
            return (state >> 1) ^ LFSR_TAPS;
         end
         return state >> 1;
      end
   endfunction

   // Step to the falling edge, drop strobe and drive tready per pattern
   task automatic next_cycle();
      begin
         @(negedge clock_i);
         strobe_i = 1'b0;
         case (ready_mode)
            0: axis_tready_i = 1'b0;
            1: axis_tready_i = 1'b1;
            default:
            begin
               axis_tready_i = lfsr[0];
               lfsr = lfsr_next(lfsr);
            end
         endcase
      end
   endtask

   // One classic cycle with ack expected at the next edge
   task automatic bus_cycle(input logic we, input logic [acq_pkg::ADR_W-1:0] adr,
                            input logic [acq_pkg::BUS_W-1:0] dat,
                            output logic [acq_pkg::BUS_W-1:0] rdata);
      int waited;
      begin
         next_cycle();
         // Any earlier ack lasted a single cycle
         check_value(32'(ack_o), 32'd0, "ack high before strobe");
         cyc_i  = 1'b1;
         stb_i  = 1'b1;
         we_i   = we;
         adr_i  = adr;
         dat_i  = dat;
         waited = 0;
         next_cycle();
         while (!ack_o && waited < 8)
         begin
            next_cycle();
            waited = waited + 1;
         end
         check_value(32'(waited), 32'd0, "extra cycles before ack");
         rdata = dat_o;
         cyc_i = 1'b0;
         stb_i = 1'b0;
         we_i  = 1'b0;
      end
   endtask

   // Count 0 gives one cycle with strobe low
   task automatic send_samples(input logic [acq_pkg::SAMPLE_W-1:0] first, input int count);
      int i;
      begin
         if (count == 0)
         begin
            next_cycle();
            signal_i = first;
         end
         for (i = 0; i < count; i++)
         begin
            next_cycle();
            signal_i = first + acq_pkg::SAMPLE_W'(i);
            strobe_i = 1'b1;
         end
      end
   endtask

   // Drain waits apply to the patterns that let beats out
   task automatic set_phase(input int mode);
      begin
         ready_mode = mode;
         next_cycle();
         if (mode != 0)
         begin
            while (model_q.size() != 0)
            begin
               next_cycle();
            end
         end
      end
   endtask

   task automatic load_golden(output bit ok);
      int          fd;
      int          c;
      int          n;
      logic [31:0] a;
      logic [31:0] b;
      begin
         ok = 1'b0;
         fd = $fopen("acq_golden.txt", "r");
         if (fd != 0)
         begin
            ok = 1'b1;
            c  = $fgetc(fd);
            while (c != -1)
            begin
               if (c == int'("#"))
               begin
                  // Skip the rest of a comment line
                  while (c != -1 && c != 10)
                  begin
                     c = $fgetc(fd);
                  end
               end
               else if (c == int'("W") || c == int'("R") || c == int'("S") || c == int'("P"))
               begin
                  n = $fscanf(fd, "%h %h", a, b);
                  if (n != 2)
                  begin
                     $display("Malformed record in acq_golden.txt after %0d records", kinds.size());
                     ok = 1'b0;
                  end
                  kinds.push_back(8'(c));
                  a_vals.push_back(a);
                  b_vals.push_back(b);
               end
               if (c != -1)
               begin
                  c = $fgetc(fd);
               end
            end
            $fclose(fd);
            if (kinds.size() == 0)
            begin
               ok = 1'b0;
            end
         end
      end
   endtask

   task automatic run_records();
      int                        i;
      logic [acq_pkg::BUS_W-1:0] rdata;
      begin
         for (i = 0; i < kinds.size(); i++)
         begin
            case (kinds[i])
               "W":
               begin
                  bus_cycle(1'b1, a_vals[i][1:0], b_vals[i][7:0], rdata);
                  // Write took effect at the ack edge
                  if (a_vals[i][1:0] == acq_pkg::REG_SYSTEM)
                  begin
                     model_enable = b_vals[i][acq_pkg::BIT_ENABLE];
                     if (!model_enable)
                     begin
                        model_oflow = 1'b0;
                     end
                  end
               end
               "R":
               begin
                  bus_cycle(1'b0, a_vals[i][1:0], 8'h00, rdata);
                  check_value(32'(rdata), b_vals[i], "register read data");
                  check_value(32'(enabled_o), 32'(model_enable), "enabled_o pin");
                  check_value(32'(oflow_o), 32'(model_oflow), "oflow_o pin");
               end
               "S": send_samples(a_vals[i][acq_pkg::SAMPLE_W-1:0], int'(b_vals[i]));
               "P": set_phase(int'(a_vals[i]));
            endcase
         end
      end
   endtask

   // --------------------------------------------------
   // Stream monitor and reference model
   // --------------------------------------------------
   always @(posedge clock_i)
   begin : monitor
      logic        full_now;
      logic [31:0] expect_data;
      // Depth before this edge decides a drop
      full_now = (model_q.size() >= acq_pkg::FIFO_DEPTH);
      if (M_AXIS_ARESETN)
      begin
         check_value(32'(axis_tvalid_o), 32'(model_q.size() != 0), "tvalid against model depth");
         if (held)
         begin
            check_value(32'(axis_tvalid_o), 32'd1, "tvalid dropped while stalled");
            check_value(axis_tdata_o, held_data, "tdata changed while stalled");
            check_value(32'(axis_tlast_o), 32'(held_last), "tlast changed while stalled");
         end
         if (axis_tvalid_o && axis_tready_i && model_q.size() != 0)
         begin
            expect_data = {{DATA_PAD{1'b0}}, model_q[0]};
            check_value(axis_tdata_o, expect_data, "tdata of accepted beat");
            check_value(32'(axis_tlast_o),
                        32'(beats % acq_pkg::FRAME_LEN == acq_pkg::FRAME_LEN - 1),
                        "tlast position in frame");
            void'(model_q.pop_front());
            beats = beats + 1;
         end
         held      = axis_tvalid_o && !axis_tready_i;
         held_data = axis_tdata_o;
         held_last = axis_tlast_o;
         if (strobe_i && model_enable)
         begin
            if (full_now)
            begin
               model_oflow = 1'b1;
            end
            else
            begin
               model_q.push_back(signal_i);
            end
         end
      end
   end

   // Run limit
   always @(posedge clock_i)
   begin
      cycles = cycles + 1;
      if (cycles >= limit)
      begin
         $display("Timeout, the run did not finish within %0d cycles", limit);
         $display("Errors found");
         $finish;
      end
   end

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial
   begin
      clock_i        = 1'b0;
      M_AXIS_ARESETN = 1'b0;
      signal_i       = '0;
      strobe_i       = 1'b0;
      cyc_i          = 1'b0;
      stb_i          = 1'b0;
      we_i           = 1'b0;
      adr_i          = '0;
      dat_i          = '0;
      axis_tready_i  = 1'b0;
      model_enable   = 1'b0;
      model_oflow    = 1'b0;
      beats          = 0;
      held           = 1'b0;
      held_data      = '0;
      held_last      = 1'b0;
      ready_mode     = 1;
      lfsr           = 32'h830e_6aeb;
      errors         = 0;
      checks         = 0;
      cycles         = 0;
      limit          = 100000;
      load_golden(loaded);
      limit = 2 * kinds.size() + 200;
      if (!loaded)
      begin
         $display("Could not read the records in acq_golden.txt");
         $display("Errors found");
         $finish;
      end
      else
      begin
         repeat (3) @(posedge clock_i);
         @(negedge clock_i);
         M_AXIS_ARESETN = 1'b1;
         // Outputs right after reset
         check_value(32'(axis_tvalid_o), 32'd0, "tvalid after reset");
         check_value(32'(axis_tlast_o), 32'd0, "tlast after reset");
         check_value(32'(ack_o), 32'd0, "ack after reset");
         check_value(32'(enabled_o), 32'd0, "enabled_o after reset");
         check_value(32'(oflow_o), 32'd0, "oflow_o after reset");
         run_records();
         next_cycle();
         next_cycle();
         $display("Checks: %0d, errors: %0d", checks, errors);
         if (errors == 0)
         begin
            $display("No errors");
         end
         else
         begin
            $display("Errors found");
         end
         $finish;
      end
   end

endmodule

// ==== acq_top.sv ====
`timescale 1ns/100ps

module acq_top
   (
   input  logic                          clock_i,
   input  logic                          M_AXIS_ARESETN,

   // Raw antenna samples
   input  logic [acq_pkg::SAMPLE_W-1:0]  signal_i,
   input  logic                          strobe_i,

   // Wishbone classic register port
   input  logic                          cyc_i,
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic [acq_pkg::ADR_W-1:0]     adr_i,
   input  logic [acq_pkg::BUS_W-1:0]     dat_i,
   output logic                          ack_o,
   output logic [acq_pkg::BUS_W-1:0]     dat_o,

   // AXI4-Stream master
   output logic                          axis_tvalid_o,
   output logic [acq_pkg::TDATA_W-1:0]   axis_tdata_o,
   output logic                          axis_tlast_o,
   input  logic                          axis_tready_i,

   // Status pins
   output logic                          enabled_o,
   output logic                          oflow_o
   );

   // --------------------------------------------------
   // Internal wiring
   // --------------------------------------------------
   acq_pkg::wb_req_t    wb_req;
   acq_pkg::wb_rsp_t    wb_rsp;
   acq_pkg::axis_beat_t beat;
   acq_pkg::sample_t    wr_data;
   acq_pkg::sample_t    head;

   logic wr_en;
   logic rd_en;
   logic full;
   logic empty;
   logic enable;
   logic clear_oflow;
   logic oflow;
   logic frame_open;

   // Bus pins into the request record
   assign wb_req = '{cyc: cyc_i, stb: stb_i, we: we_i, adr: adr_i, dat: dat_i};

   // Response and stream records onto pins
   assign ack_o         = wb_rsp.ack;
   assign dat_o         = wb_rsp.dat;
   assign axis_tdata_o  = beat.tdata;
   assign axis_tlast_o  = beat.tlast;
   assign enabled_o     = enable;
   assign oflow_o       = oflow;

   acq_capture u_capture (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .signal_i       (signal_i),
      .strobe_i       (strobe_i),
      .enable_i       (enable),
      .clear_oflow_i  (clear_oflow),
      .full_i         (full),
      .wr_en_o        (wr_en),
      .wr_data_o      (wr_data),
      .oflow_o        (oflow)
   );

   acq_fifo u_fifo (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .wr_en_i        (wr_en),
      .wr_data_i      (wr_data),
      .rd_en_i        (rd_en),
      .rd_data_o      (head),
      .full_o         (full),
      .empty_o        (empty)
   );

   acq_axis_framer u_framer (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .head_i         (head),
      .empty_i        (empty),
      .rd_en_o        (rd_en),
      .beat_o         (beat),
      .tvalid_o       (axis_tvalid_o),
      .tready_i       (axis_tready_i),
      .frame_open_o   (frame_open)
   );

   acq_regs u_regs (
      .clock_i        (clock_i),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .req_i          (wb_req),
      .rsp_o          (wb_rsp),
      .oflow_i        (oflow),
      .frame_open_i   (frame_open),
      .enable_o       (enable),
      .clear_oflow_o  (clear_oflow)
   );

endmodule

// ==== acq_unit.f ====
acq_pkg.sv
acq_capture.sv
acq_fifo.sv
acq_axis_framer.sv
acq_regs.sv
acq_top.sv
acq_tb.sv
